// ==== build.f ====
src/lsu_pkg.sv
src/lsu_ifs.sv
src/lsu_req_prep.sv
src/lsu_entry.sv
src/lsu_issue.sv
src/lsu_rsp_track.sv
src/lsu_result.sv
src/lsu_top.sv
tests/lsu_checker.sv
tests/lsu_tb.sv

// ==== run.sh ====
#!/bin/sh
# compiles the LSU testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module lsu_tb \
	-Mdir obj_dir -f build.f
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit $status
fi

./obj_dir/Vlsu_tb
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi

exit 0

// ==== tests/lsu_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// table ids must be unique
// bus memory decodes addr bits 7:2 only
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module lsu_tb import lsu_pkg::*; ();
	localparam int ROW_N     = 16;
	localparam int CYCLE_MAX = ROW_N * 60;

	typedef struct packed {
		logic                 store;
		logic [2:0]           ls_type;
		logic [31:0]          addr;
		logic [31:0]          wdata;
		logic [INST_ID_W-1:0] id;
		logic [1:0]           exp_err;
		logic [31:0]          exp_data; // unused for good stores
	} row_t;

	logic                 clk;
	logic                 resetn;
	logic                 req_store_i;
	logic [2:0]           req_type_i;
	logic [4:0]           req_rd_i;
	logic [31:0]          req_addr_i;
	logic [31:0]          req_wdata_i;
	logic [INST_ID_W-1:0] req_id_i;
	logic                 req_valid_i;
	logic                 req_ready_o;
	logic                 res_store_o;
	logic [4:0]           res_rd_o;
	logic [31:0]          res_data_o;
	logic [1:0]           res_err_o;
	logic [INST_ID_W-1:0] res_id_o;
	logic                 res_valid_o;
	logic                 res_ready_i;
	logic [31:0]          icb_cmd_addr_o;
	logic                 icb_cmd_read_o;
	logic [31:0]          icb_cmd_wdata_o;
	logic [3:0]           icb_cmd_wmask_o;
	logic                 icb_cmd_valid_o;
	logic                 icb_cmd_ready_i;
	logic [31:0]          icb_rsp_rdata_i;
	logic                 icb_rsp_err_i;
	logic                 icb_rsp_valid_i;
	logic                 icb_rsp_ready_o;

	row_t             rows [ROW_N];
	logic [31:0]      mem [64];
	logic [32:0]      rsp_q [$]; // {err, rdata} in command order
	logic [ROW_N-1:0] seen;
	integer           seed;
	int               row_idx;
	int               res_cnt;
	int               cycles;
	logic             rsp_fire;

	lsu_top u_dut (.*);

	always #2 clk = ~clk;

	task automatic stop_with_failure(input string msg);
		$display("%s", msg);
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
		assert (got === exp)
		else
			stop_with_failure($sformatf("** Error at %0t: %s is %h, expected %h",
				$time, what, got, exp));
	endtask

	task automatic load_table();
		rows[0]  = '{1'b1, LS_WORD,   32'h10, 32'h1122_3344, 4'd0, ERR_NONE, 32'h0};
		rows[1]  = '{1'b1, LS_BYTE,   32'h11, 32'h0000_00ab, 4'd1, ERR_NONE, 32'h0};
		rows[2]  = '{1'b1, LS_HALF,   32'h12, 32'h0000_cdef, 4'd2, ERR_NONE, 32'h0};
		rows[3]  = '{1'b0, LS_WORD,   32'h10, 32'h0, 4'd3, ERR_NONE, 32'hcdef_ab44};
		rows[4]  = '{1'b1, LS_WORD,   32'h20, 32'h80f1_7f32, 4'd4, ERR_NONE, 32'h0};
		rows[5]  = '{1'b0, LS_BYTE,   32'h20, 32'h0, 4'd5, ERR_NONE, 32'h0000_0032};
		rows[6]  = '{1'b0, LS_BYTE,   32'h21, 32'h0, 4'd6, ERR_NONE, 32'h0000_007f};
		rows[7]  = '{1'b0, LS_BYTE,   32'h22, 32'h0, 4'd7, ERR_NONE, 32'hffff_fff1};
		rows[8]  = '{1'b0, LS_BYTE_U, 32'h23, 32'h0, 4'd8, ERR_NONE, 32'h0000_0080};
		rows[9]  = '{1'b0, LS_HALF,   32'h22, 32'h0, 4'd9, ERR_NONE, 32'hffff_80f1};
		rows[10] = '{1'b0, LS_HALF_U, 32'h22, 32'h0, 4'd10, ERR_NONE, 32'h0000_80f1};
		rows[11] = '{1'b0, LS_WORD,   32'h1a, 32'h0, 4'd11, ERR_MISALIGN, 32'h1a};
		rows[12] = '{1'b1, LS_HALF,   32'h27, 32'h5555, 4'd12, ERR_MISALIGN, 32'h27};
		rows[13] = '{1'b0, LS_WORD,   32'h8000_0040, 32'h0, 4'd13, ERR_BUS, 32'h8000_0040};
		rows[14] = '{1'b1, LS_BYTE,   32'h8000_0003, 32'h77, 4'd14, ERR_BUS, 32'h8000_0003};
		rows[15] = '{1'b0, LS_HALF,   32'h20, 32'h0, 4'd15, ERR_NONE, 32'h0000_7f32};
	endtask

	// results come back out of order, so look the row up by id
	task automatic check_result();
		int   k;
		logic found;
		row_t r;
		found = 1'b0;
		r     = rows[0];
		for (k = 0; k < ROW_N; k++)
		begin
			if (rows[k].id == res_id_o)
			begin
				found = 1'b1;
				r     = rows[k];
			end
		end
		assert (found)
		else
			stop_with_failure($sformatf("** Error at %0t: result with unknown id %0d",
				$time, res_id_o));
		assert (!seen[res_id_o])
		else
			stop_with_failure($sformatf("** Error at %0t: second result for id %0d",
				$time, res_id_o));
		check_value(32'(res_err_o), 32'(r.exp_err), "error code");
		check_value(32'(res_store_o), 32'(r.store), "store flag");
		check_value(32'(res_rd_o), 32'(5'(r.id) + 5'd1), "rd");
		if (!r.store || r.exp_err != ERR_NONE)
			check_value(res_data_o, r.exp_data, "result data");
		seen[res_id_o] = 1'b1;
		res_cnt++;
	endtask

	// bus slave writes through the mask and faults any address with bit 31 set
	task automatic bus_command();
		logic [5:0] idx;
		idx = icb_cmd_addr_o[7:2];
		for (int k = 0; k < ROW_N; k++)
			if (rows[k].exp_err == ERR_MISALIGN)
				assert (icb_cmd_addr_o != rows[k].addr)
				else
					stop_with_failure($sformatf("** Error at %0t: misaligned address %h on bus",
						$time, icb_cmd_addr_o));
		if (icb_cmd_addr_o[31])
			rsp_q.push_back({1'b1, 32'h0});
		else if (icb_cmd_read_o)
			rsp_q.push_back({1'b0, mem[idx]});
		else
		begin
			for (int b = 0; b < 4; b++)
				if (icb_cmd_wmask_o[b])
					mem[idx][8*b +: 8] = icb_cmd_wdata_o[8*b +: 8];
			rsp_q.push_back({1'b0, 32'h0});
		end
	endtask

	// sampled mid-cycle when everything is settled
	task automatic observe();
		rsp_fire = icb_rsp_valid_i & icb_rsp_ready_o;
		if (icb_cmd_valid_o && icb_cmd_ready_i)
			bus_command();
		if (rsp_fire)
			void'(rsp_q.pop_front());
		if (res_valid_o && res_ready_i)
			check_result();
		if (req_valid_i && req_ready_o)
			row_idx++;
	endtask

	task automatic drive_inputs();
		if (row_idx < ROW_N)
		begin
			req_valid_i = 1'b1;
			req_store_i = rows[row_idx].store;
			req_type_i  = rows[row_idx].ls_type;
			req_rd_i    = 5'(rows[row_idx].id) + 5'd1;
			req_addr_i  = rows[row_idx].addr;
			req_wdata_i = rows[row_idx].wdata;
			req_id_i    = rows[row_idx].id;
		end
		else
			req_valid_i = 1'b0;
		icb_cmd_ready_i = (($random(seed) & 3) != 0);
		res_ready_i     = (($random(seed) & 3) != 0);
		if (!icb_rsp_valid_i || rsp_fire) // a raised response waits for ready
		begin
			icb_rsp_valid_i = 1'b0;
			if (rsp_q.size() != 0 && (($random(seed) & 1) != 0))
			begin
				icb_rsp_valid_i = 1'b1;
				{icb_rsp_err_i, icb_rsp_rdata_i} = rsp_q[0];
			end
		end
	endtask

	initial
	begin
		clk             = 1'b0;
		resetn          = 1'b0;
		req_store_i     = 1'b0;
		req_type_i      = LS_WORD;
		req_rd_i        = '0;
		req_addr_i      = '0;
		req_wdata_i     = '0;
		req_id_i        = '0;
		req_valid_i     = 1'b0;
		res_ready_i     = 1'b0;
		icb_cmd_ready_i = 1'b0;
		icb_rsp_rdata_i = '0;
		icb_rsp_err_i   = 1'b0;
		icb_rsp_valid_i = 1'b0;
		seed            = 32'hb852_c510;
		seen            = '0;
		row_idx         = 0;
		res_cnt         = 0;
		cycles          = 0;
		rsp_fire        = 1'b0;
		load_table();
		for (int i = 0; i < 64; i++)
			mem[i] = 32'h9e37_79b9 * 32'(i + 1); // differs for every word
		repeat (2) @(posedge clk);
		#1;
		resetn = 1'b1;
		drive_inputs();
		while (res_cnt < ROW_N)
		begin
			@(negedge clk);
			observe();
			@(posedge clk);
			#1;
			drive_inputs();
			cycles++;
			if (cycles > CYCLE_MAX)
				stop_with_failure($sformatf("timeout after %0d cycles with %0d of %0d results",
					cycles, res_cnt, ROW_N));
		end
		if (&seen && rsp_q.size() == 0)
		begin
			$display("Everything OK");
			$finish;
		end
		else
			stop_with_failure("run ended with missing results or bus responses left over");
	end

endmodule

`default_nettype wire

// ==== tests/lsu_checker.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bound into lsu_top and watches only its ports
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module lsu_checker import lsu_pkg::*; (
	input logic                 clk,
	input logic                 resetn,
	input logic [31:0]          icb_cmd_addr_o,
	input logic                 icb_cmd_read_o,
	input logic [31:0]          icb_cmd_wdata_o,
	input logic [3:0]           icb_cmd_wmask_o,
	input logic                 icb_cmd_valid_o,
	input logic                 icb_cmd_ready_i,
	input logic [31:0]          res_data_o,
	input logic [1:0]           res_err_o,
	input logic [INST_ID_W-1:0] res_id_o,
	input logic                 res_valid_o,
	input logic                 res_ready_i
);
	cmd_hold: assert property (@(posedge clk) disable iff (!resetn)
		icb_cmd_valid_o && !icb_cmd_ready_i |=> icb_cmd_valid_o && $stable(icb_cmd_addr_o)
		&& $stable(icb_cmd_read_o) && $stable(icb_cmd_wdata_o) && $stable(icb_cmd_wmask_o))
		else $error("bus command changed while stalled");

	res_hold: assert property (@(posedge clk) disable iff (!resetn)
		res_valid_o && !res_ready_i |=> res_valid_o && $stable(res_id_o)
		&& $stable(res_data_o) && $stable(res_err_o))
		else $error("result changed while stalled");

	// reads never write lanes
	read_mask: assert property (@(posedge clk) disable iff (!resetn)
		icb_cmd_valid_o && icb_cmd_read_o |-> icb_cmd_wmask_o == 4'b0000)
		else $error("read command with nonzero mask");
endmodule

bind lsu_top lsu_checker u_checker (.*);

`default_nettype wire

// ==== src/lsu_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ICB data master, up to two commands outstanding
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module lsu_top import lsu_pkg::*; (
	input  logic                 clk,
	input  logic                 resetn,
	input  logic                 req_store_i,
	input  logic [2:0]           req_type_i,
	input  logic [4:0]           req_rd_i,
	input  logic [31:0]          req_addr_i,
	input  logic [31:0]          req_wdata_i,
	input  logic [INST_ID_W-1:0] req_id_i,
	input  logic                 req_valid_i,
	output logic                 req_ready_o,
	output logic                 res_store_o,
	output logic [4:0]           res_rd_o,
	output logic [31:0]          res_data_o, // load data, or address on error
	output logic [1:0]           res_err_o,
	output logic [INST_ID_W-1:0] res_id_o,
	output logic                 res_valid_o,
	input  logic                 res_ready_i,
	output logic [31:0]          icb_cmd_addr_o,
	output logic                 icb_cmd_read_o,
	output logic [31:0]          icb_cmd_wdata_o,
	output logic [3:0]           icb_cmd_wmask_o,
	output logic                 icb_cmd_valid_o,
	input  logic                 icb_cmd_ready_i,
	input  logic [31:0]          icb_rsp_rdata_i,
	input  logic                 icb_rsp_err_i,
	input  logic                 icb_rsp_valid_i,
	output logic                 icb_rsp_ready_o
);
	logic      launch;
	slot_idx_t launch_slot;
	logic      room;
	logic      head_vld;
	slot_idx_t head_slot;
	logic      pop;

	lsu_alloc_if alloc ();
	lsu_slot_if  slots ();
	lsu_fill_if  fill ();

	lsu_req_prep u_req_prep (.*, .alloc(alloc), .slots(slots));

	for (genvar i = 0; i < ENTRY_N; i++)
	begin : g_entry
		lsu_entry u_entry (
			.clk     (clk),
			.resetn  (resetn),
			.alloc   (alloc),
			.fill    (fill),
			.slots   (slots),
			.slot_id (slot_idx_t'(i))
		);
	end

	lsu_issue u_issue (
		.*,
		.slots         (slots),
		.room_i        (room),
		.launch_o      (launch),
		.launch_slot_o (launch_slot)
	);

	lsu_rsp_track u_rsp_track (
		.*,
		.launch_i      (launch),
		.launch_slot_i (launch_slot),
		.room_o        (room),
		.slots         (slots),
		.fill          (fill),
		.head_vld_o    (head_vld),
		.head_slot_o   (head_slot),
		.pop_i         (pop)
	);

	lsu_result u_result (
		.*,
		.slots       (slots),
		.head_vld_i  (head_vld),
		.head_slot_i (head_slot),
		.pop_o       (pop)
	);

endmodule

`default_nettype wire

// ==== src/lsu_result.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// a misaligned slot bypasses bus results
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module lsu_result import lsu_pkg::*; (
	input  logic                 clk,
	input  logic                 resetn,
	lsu_slot_if.result           slots,
	input  logic                 head_vld_i,
	input  slot_idx_t            head_slot_i,
	output logic                 pop_o,
	output logic                 res_store_o,
	output logic [4:0]           res_rd_o,
	output logic [31:0]          res_data_o,
	output logic [1:0]           res_err_o,
	output logic [INST_ID_W-1:0] res_id_o,
	output logic                 res_valid_o,
	input  logic                 res_ready_i
);
	logic      locked_q;
	logic      use_mis_q; // choice held during a stall
	logic      use_mis;
	logic      mis_any;
	slot_idx_t mis_slot;
	slot_idx_t sel;
	logic      fire;

	assign mis_any = |slots.misaligned;

	// at most one bit is set
	always_comb
	begin
		mis_slot = '0;
		for (int i = 0; i < ENTRY_N; i++)
			if (slots.misaligned[i])
				mis_slot = slot_idx_t'(i);
	end

	assign use_mis     = locked_q ? use_mis_q : mis_any;
	assign sel         = use_mis ? mis_slot : head_slot_i;
	assign res_valid_o = mis_any | head_vld_i;
	assign fire        = res_valid_o & res_ready_i;
	assign pop_o       = fire & ~use_mis;

	assign slots.free_vld  = fire;
	assign slots.free_slot = sel;

	assign res_store_o = slots.store[sel];
	assign res_rd_o    = slots.rd[sel];
	assign res_err_o   = slots.err[sel];
	assign res_id_o    = slots.id[sel];
	assign res_data_o  = (slots.err[sel] == ERR_NONE) ? slots.data[sel] : slots.addr[sel];

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
			locked_q <= 1'b0;
		else if (locked_q)
		begin
			if (res_ready_i)
				locked_q <= 1'b0;
		end
		else if (res_valid_o & ~res_ready_i)
			locked_q <= 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (!locked_q & res_valid_o & ~res_ready_i)
			use_mis_q <= mis_any;
	end

endmodule

`default_nettype wire

// ==== src/lsu_rsp_track.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// assumes bus responses return in command order
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module lsu_rsp_track import lsu_pkg::*; (
	input  logic        clk,
	input  logic        resetn,
	input  logic        launch_i,
	input  slot_idx_t   launch_slot_i,
	output logic        room_o,
	input  logic [31:0] icb_rsp_rdata_i,
	input  logic        icb_rsp_err_i,
	input  logic        icb_rsp_valid_i,
	output logic        icb_rsp_ready_o,
	lsu_slot_if.rsp     slots,
	lsu_fill_if.source  fill,
	output logic        head_vld_o,
	output slot_idx_t   head_slot_o,
	input  logic        pop_i
);
	slot_idx_t         q_slot [OUTSTANDING_N];
	logic [QPTR_W-1:0] lptr_q; // next launch
	logic [QPTR_W-1:0] rptr_q; // next bus response
	logic [QPTR_W-1:0] pptr_q; // next reported result
	slot_idx_t         rsp_slot;
	logic [2:0]        rsp_type;
	logic [31:0]       shifted;
	logic [31:0]       ext;
	logic              rsp_fire;

	// full when launch is a whole lap ahead of the result pointer
	assign room_o = (lptr_q[QPTR_W-1] == pptr_q[QPTR_W-1]) |
		(lptr_q[QPTR_W-2:0] != pptr_q[QPTR_W-2:0]);

	assign icb_rsp_ready_o = (lptr_q != rptr_q);
	assign head_vld_o      = (rptr_q != pptr_q); // response in, not yet reported
	assign head_slot_o     = q_slot[pptr_q[QPTR_W-2:0]];
	assign rsp_slot        = q_slot[rptr_q[QPTR_W-2:0]];
	assign rsp_fire        = icb_rsp_valid_i & icb_rsp_ready_o;

	assign rsp_type = slots.ls_type[rsp_slot];
	assign shifted  = icb_rsp_rdata_i >> {slots.addr[rsp_slot][1:0], 3'b000};

	always_comb
	begin
		case (rsp_type)
			LS_BYTE:   ext = {{24{shifted[7]}}, shifted[7:0]};
			LS_BYTE_U: ext = {24'd0, shifted[7:0]};
			LS_HALF:   ext = {{16{shifted[15]}}, shifted[15:0]};
			LS_HALF_U: ext = {16'd0, shifted[15:0]};
			default:   ext = shifted;
		endcase
	end

	assign fill.fill_vld  = rsp_fire;
	assign fill.fill_slot = rsp_slot;
	assign fill.fill_data = ext;
	assign fill.fill_err  = icb_rsp_err_i ? ERR_BUS : ERR_NONE;

	always_ff @(posedge clk)
	begin
		if (launch_i)
			q_slot[lptr_q[QPTR_W-2:0]] <= launch_slot_i;
	end

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			lptr_q <= '0;
			rptr_q <= '0;
			pptr_q <= '0;
		end
		else
		begin
			if (launch_i)
				lptr_q <= lptr_q + 1'b1;
			if (rsp_fire)
				rptr_q <= rptr_q + 1'b1;
			if (pop_i)
				pptr_q <= pptr_q + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== src/lsu_issue.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// command is held stable while the bus stalls it
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module lsu_issue import lsu_pkg::*; (
	input  logic        clk,
	input  logic        resetn,
	lsu_slot_if.issue   slots,
	output logic [31:0] icb_cmd_addr_o,
	output logic        icb_cmd_read_o,
	output logic [31:0] icb_cmd_wdata_o,
	output logic [3:0]  icb_cmd_wmask_o,
	output logic        icb_cmd_valid_o,
	input  logic        icb_cmd_ready_i,
	input  logic        room_i,
	output logic        launch_o,
	output slot_idx_t   launch_slot_o
);
	logic               locked_q;
	logic [ENTRY_N-1:0] cand_q; // candidates frozen at the stall
	logic [ENTRY_N-1:0] cand;
	logic               win;
	slot_idx_t          sel;

	// a allocated before b, wrap bit flips the order
	function automatic logic older(input logic [AGE_W-1:0] a, input logic [AGE_W-1:0] b);
		if (a[AGE_W-1] == b[AGE_W-1])
			return a[AGE_W-2:0] < b[AGE_W-2:0];
		return a[AGE_W-2:0] > b[AGE_W-2:0];
	endfunction

	assign cand = locked_q ? cand_q : slots.pending;

	// oldest candidate wins
	always_comb
	begin
		sel = '0;
		win = 1'b0;
		for (int i = 0; i < ENTRY_N; i++)
		begin
			win = cand[i];
			for (int j = 0; j < ENTRY_N; j++)
				if (j != i && cand[j] && !older(slots.age[i], slots.age[j]))
					win = 1'b0;
			if (win)
				sel = slot_idx_t'(i);
		end
	end

	assign icb_cmd_valid_o = (|cand) & room_i;
	assign icb_cmd_addr_o  = slots.addr[sel];
	assign icb_cmd_read_o  = ~slots.store[sel];
	assign icb_cmd_wdata_o = slots.data[sel];
	assign icb_cmd_wmask_o = slots.wmask[sel];

	assign launch_o          = icb_cmd_valid_o & icb_cmd_ready_i;
	assign launch_slot_o     = sel;
	assign slots.launch_vld  = launch_o;
	assign slots.launch_slot = sel;

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
			locked_q <= 1'b0;
		else if (locked_q)
		begin
			if (icb_cmd_ready_i)
				locked_q <= 1'b0;
		end
		else if (icb_cmd_valid_o & ~icb_cmd_ready_i)
			locked_q <= 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (!locked_q & icb_cmd_valid_o & ~icb_cmd_ready_i)
			cand_q <= slots.pending;
	end

endmodule

`default_nettype wire

// ==== src/lsu_entry.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// slot_id must be tied to a constant
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module lsu_entry import lsu_pkg::*; (
	input  logic      clk,
	input  logic      resetn,
	lsu_alloc_if.sink alloc,
	lsu_fill_if.sink  fill,
	lsu_slot_if.entry slots,
	input  slot_idx_t slot_id
);
	logic                 take;
	logic                 fill_hit;
	logic                 free_hit;
	logic                 launch_hit;
	logic                 busy_q;
	logic                 launched_q;
	logic                 aligned_q;
	logic                 store_q;
	logic [AGE_W-1:0]     age_q;
	logic [2:0]           type_q;
	logic [4:0]           rd_q;
	logic [31:0]          addr_q;
	logic [31:0]          data_q; // write data, later the load result
	logic [3:0]           wmask_q;
	logic [INST_ID_W-1:0] id_q;
	logic [1:0]           err_q;

	assign take       = alloc.alloc_vld & (alloc.alloc_slot == slot_id);
	assign fill_hit   = fill.fill_vld & (fill.fill_slot == slot_id);
	assign free_hit   = slots.free_vld & (slots.free_slot == slot_id);
	assign launch_hit = slots.launch_vld & (slots.launch_slot == slot_id);

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			busy_q     <= 1'b0;
			launched_q <= 1'b0;
			aligned_q  <= 1'b0;
		end
		else if (take)
		begin
			busy_q     <= 1'b1;
			launched_q <= 1'b0;
			aligned_q  <= alloc.aligned;
		end
		else
		begin
			if (free_hit)
				busy_q <= 1'b0;
			if (launch_hit)
				launched_q <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (take)
		begin
			store_q <= alloc.store;
			age_q   <= alloc.alloc_age;
			type_q  <= alloc.ls_type;
			rd_q    <= alloc.rd;
			addr_q  <= alloc.addr;
			data_q  <= alloc.data;
			wmask_q <= alloc.wmask;
			id_q    <= alloc.id;
			err_q   <= alloc.aligned ? ERR_NONE : ERR_MISALIGN;
		end
		else if (fill_hit)
		begin
			err_q <= fill.fill_err;
			if (!store_q)
				data_q <= fill.fill_data;
		end
	end

	assign slots.busy[slot_id]       = busy_q;
	assign slots.pending[slot_id]    = busy_q & aligned_q & ~launched_q;
	assign slots.misaligned[slot_id] = busy_q & ~aligned_q;
	assign slots.store[slot_id]      = store_q;
	assign slots.age[slot_id]        = age_q;
	assign slots.ls_type[slot_id]    = type_q;
	assign slots.rd[slot_id]         = rd_q;
	assign slots.addr[slot_id]       = addr_q;
	assign slots.data[slot_id]       = data_q;
	assign slots.wmask[slot_id]      = wmask_q;
	assign slots.id[slot_id]         = id_q;
	assign slots.err[slot_id]        = err_q;

endmodule

`default_nettype wire

// ==== src/lsu_req_prep.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// slots are allocated strictly in order
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module lsu_req_prep import lsu_pkg::*; (
	input  logic                 clk,
	input  logic                 resetn,
	input  logic                 req_store_i,
	input  logic [2:0]           req_type_i,
	input  logic [4:0]           req_rd_i,
	input  logic [31:0]          req_addr_i,
	input  logic [31:0]          req_wdata_i,
	input  logic [INST_ID_W-1:0] req_id_i,
	input  logic                 req_valid_i,
	output logic                 req_ready_o,
	lsu_alloc_if.source          alloc,
	lsu_slot_if.prep             slots
);
	logic [AGE_W-1:0] wptr_q; // write pointer with wrap bit
	slot_idx_t        wslot;
	logic             aligned;
	logic [31:0]      pk_data;
	logic [3:0]       pk_mask;
	logic             fire;

	assign wslot = wptr_q[AGE_W-2:0];

	// only one misaligned slot may wait at a time
	assign req_ready_o = ~slots.busy[wslot] & ~(|slots.misaligned);
	assign fire        = req_valid_i & req_ready_o;

	always_comb
	begin
		aligned = 1'b0;
		pk_data = req_wdata_i;
		pk_mask = 4'b0000;
		case (req_type_i)
			LS_BYTE, LS_BYTE_U:
			begin
				aligned = 1'b1;
				pk_data = {4{req_wdata_i[7:0]}};
				pk_mask = 4'b0001 << req_addr_i[1:0];
			end
			LS_HALF, LS_HALF_U:
			begin
				aligned = ~req_addr_i[0];
				pk_data = {2{req_wdata_i[15:0]}};
				pk_mask = 4'b0011 << {req_addr_i[1], 1'b0};
			end
			LS_WORD:
			begin
				aligned = (req_addr_i[1:0] == 2'b00);
				pk_mask = 4'b1111;
			end
			default: ; // unknown type reported as misaligned
		endcase
	end

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
			wptr_q <= '0;
		else if (fire)
			wptr_q <= wptr_q + 1'b1;
	end

	assign alloc.alloc_vld  = fire;
	assign alloc.alloc_slot = wslot;
	assign alloc.alloc_age  = wptr_q;
	assign alloc.store      = req_store_i;
	assign alloc.ls_type    = req_type_i;
	assign alloc.rd         = req_rd_i;
	assign alloc.addr       = req_addr_i;
	assign alloc.data       = pk_data;
	assign alloc.wmask      = req_store_i ? pk_mask : 4'b0000; // reads carry no mask
	assign alloc.id         = req_id_i;
	assign alloc.aligned    = aligned;

endmodule

`default_nettype wire

// ==== src/lsu_ifs.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// slot arrays are written one element per lsu_entry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

interface lsu_alloc_if import lsu_pkg::*; ();
	logic                 alloc_vld;
	slot_idx_t            alloc_slot;
	logic [AGE_W-1:0]     alloc_age;
	logic                 store;
	logic [2:0]           ls_type;
	logic [4:0]           rd;
	logic [31:0]          addr;
	logic [31:0]          data; // already replicated over the lanes
	logic [3:0]           wmask;
	logic [INST_ID_W-1:0] id;
	logic                 aligned;

	modport source (output alloc_vld, alloc_slot, alloc_age, store, ls_type, rd, addr,
		data, wmask, id, aligned);
	modport sink (input alloc_vld, alloc_slot, alloc_age, store, ls_type, rd, addr,
		data, wmask, id, aligned);
endinterface

interface lsu_slot_if import lsu_pkg::*; ();
	logic [ENTRY_N-1:0]   busy;
	logic [ENTRY_N-1:0]   pending; // aligned, not yet on the bus
	logic [ENTRY_N-1:0]   misaligned;
	logic [ENTRY_N-1:0]   store;
	logic [AGE_W-1:0]     age [ENTRY_N];
	logic [2:0]           ls_type [ENTRY_N];
	logic [4:0]           rd [ENTRY_N];
	logic [31:0]          addr [ENTRY_N];
	logic [31:0]          data [ENTRY_N];
	logic [3:0]           wmask [ENTRY_N];
	logic [INST_ID_W-1:0] id [ENTRY_N];
	logic [1:0]           err [ENTRY_N];
	logic                 launch_vld; // command handshake
	slot_idx_t            launch_slot;
	logic                 free_vld; // result handshake
	slot_idx_t            free_slot;

	modport entry (output busy, pending, misaligned, store, age, ls_type, rd, addr, data,
		wmask, id, err, input launch_vld, launch_slot, free_vld, free_slot);
	modport prep (input busy, misaligned);
	modport issue (input pending, age, addr, store, data, wmask,
		output launch_vld, launch_slot);
	modport result (input busy, pending, misaligned, store, age, ls_type, rd, addr, data,
		wmask, id, err, output free_vld, free_slot);
	modport rsp (input ls_type, addr);
endinterface

interface lsu_fill_if import lsu_pkg::*; ();
	logic        fill_vld;
	slot_idx_t   fill_slot;
	logic [31:0] fill_data; // load data, aligned and extended
	logic [1:0]  fill_err;

	modport source (output fill_vld, fill_slot, fill_data, fill_err);
	modport sink (input fill_vld, fill_slot, fill_data, fill_err);
endinterface

`default_nettype wire

// ==== src/lsu_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ENTRY_N and OUTSTANDING_N must be powers of two
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package lsu_pkg;

	localparam int ENTRY_N       = 4; // buffer slots
	localparam int SLOT_W        = $clog2(ENTRY_N);
	localparam int AGE_W         = SLOT_W + 1; // slot index plus wrap bit
	localparam int OUTSTANDING_N = 2; // bus transactions in flight
	localparam int QPTR_W        = $clog2(OUTSTANDING_N) + 1;
	localparam int INST_ID_W     = 4;

	typedef logic [SLOT_W-1:0] slot_idx_t;

	// access type, top bit marks an unsigned load, low bits the size
	localparam logic [2:0] LS_BYTE   = 3'b000;
	localparam logic [2:0] LS_HALF   = 3'b001;
	localparam logic [2:0] LS_WORD   = 3'b010;
	localparam logic [2:0] LS_BYTE_U = 3'b100;
	localparam logic [2:0] LS_HALF_U = 3'b101;

	// completion codes
	localparam logic [1:0] ERR_NONE     = 2'b00;
	localparam logic [1:0] ERR_MISALIGN = 2'b01;
	localparam logic [1:0] ERR_BUS      = 2'b10;

endpackage

`default_nettype wire
